/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = tb_rv_core
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass message appears on a line of its own.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import core_pkg::*; (
   input  pipeline_bus_t   id_bus_i,
   output logic [XLEN-1:0] result_o,
   output logic            taken_o
);

   logic [XLEN-1:0] op_a;
   logic [XLEN-1:0] op_b;
   logic [4:0]      shamt;

   assign op_a  = id_bus_i.rs1_data;
   assign op_b  = (id_bus_i.format == R_FORMAT) ? id_bus_i.rs2_data : id_bus_i.imm;
   assign shamt = op_b[4:0];

   always_comb begin
      case (id_bus_i.alu_op)
         ALU_ADD:   result_o = op_a + op_b;
         ALU_SUB:   result_o = op_a - op_b;
         ALU_SLL:   result_o = op_a << shamt;
         ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
         ALU_XOR:   result_o = op_a ^ op_b;
         ALU_SRL:   result_o = op_a >> shamt;
         ALU_SRA:   result_o = $unsigned($signed(op_a) >>> shamt);
         ALU_OR:    result_o = op_a | op_b;
         ALU_AND:   result_o = op_a & op_b;
         ALU_LUI:   result_o = id_bus_i.imm;
         ALU_AUIPC: result_o = id_bus_i.pc + id_bus_i.imm;
         default:   result_o = '0;
      endcase
   end

   // Branches always compare the two register operands.
   always_comb begin
      case (id_bus_i.alu_op)
         ALU_BEQ:  taken_o = (id_bus_i.rs1_data == id_bus_i.rs2_data);
         ALU_BNE:  taken_o = (id_bus_i.rs1_data != id_bus_i.rs2_data);
         ALU_BLT:  taken_o = ($signed(id_bus_i.rs1_data) < $signed(id_bus_i.rs2_data));
         ALU_BGE:  taken_o = ($signed(id_bus_i.rs1_data) >= $signed(id_bus_i.rs2_data));
         ALU_BLTU: taken_o = (id_bus_i.rs1_data < id_bus_i.rs2_data);
         ALU_BGEU: taken_o = (id_bus_i.rs1_data >= id_bus_i.rs2_data);
         default:  taken_o = 1'b0;
      endcase
      taken_o = taken_o && id_bus_i.is_branch;
   end

endmodule

`default_nettype wire

/* hdl/core_control.sv */
`timescale 1ns/1ns
`default_nettype none

module core_control import core_pkg::*; (
   input  wire             clk,
   input  wire             rst_n_i,
   input  logic [XLEN-1:0] imem_data_i,
   input  pipeline_bus_t   id_bus_i,
   output logic [XLEN-1:0] instr_o,
   output logic            step_o,
   output logic            rf_wen_o,
   output logic            retire_o,
   output logic            halted_o
);

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      HALT
   } state_t;

   state_t          state_q;
   logic [XLEN-1:0] instr_q;
   logic            trap;
   logic            writes_rd;

   // Anything the core cannot execute stops it.
   assign trap = id_bus_i.illegal || (id_bus_i.mem_op != MEM_NOP);

   assign writes_rd = (id_bus_i.format == I_FORMAT) || (id_bus_i.format == U_FORMAT) ||
                      (id_bus_i.format == R_FORMAT);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= FETCH;
      end else begin
         case (state_q)
            FETCH:   state_q <= EXEC;
            EXEC:    state_q <= trap ? HALT : FETCH;
            default: state_q <= HALT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == FETCH) begin
         instr_q <= imem_data_i;
      end
   end

   assign instr_o  = instr_q;
   assign retire_o = (state_q == EXEC);
   assign step_o   = retire_o && !trap;
   assign rf_wen_o = step_o && writes_rd;
   assign halted_o = (state_q == HALT);

   a_no_step_when_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(step_o && halted_o))
      else $error("Step issued while halted.");

   a_retire_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      retire_o |=> !retire_o)
      else $error("Retire strobe held for two cycles.");

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

   localparam int unsigned XLEN = 32;
   localparam logic [XLEN-1:0] RESET_PC = '0;

   typedef enum logic [6:0] {
      I_OP    = 7'b0010011,
      RR_OP   = 7'b0110011,
      LUI_OP  = 7'b0110111,
      AUI_OP  = 7'b0010111,
      B_OP    = 7'b1100011,
      L_OP    = 7'b0000011,
      S_OP    = 7'b0100011,
      JAL_OP  = 7'b1101111,
      JALR_OP = 7'b1100111,
      E_OP    = 7'b1110011
   } opcode_t;

   typedef logic [4:0] reg_t;

   typedef enum logic [2:0] {
      NOP,
      I_FORMAT,
      S_FORMAT,
      B_FORMAT,
      U_FORMAT,
      R_FORMAT
   } format_t;

   // Operation codes are built as {prefix, alternate bit, funct3}.
   localparam logic [1:0] ARITHM_PRFX = 2'b00;
   localparam logic [1:0] BRANCH_PRFX = 2'b01;
   localparam logic [1:0] LOAD_PRFX   = 2'b10;
   localparam logic [1:0] STORE_PRFX  = 2'b11;

   typedef enum logic [5:0] {
      ALU_ADD   = 6'b000000,
      ALU_SLL   = 6'b000001,
      ALU_SLT   = 6'b000010,
      ALU_SLTU  = 6'b000011,
      ALU_XOR   = 6'b000100,
      ALU_SRL   = 6'b000101,
      ALU_OR    = 6'b000110,
      ALU_AND   = 6'b000111,
      ALU_SUB   = 6'b001000,
      ALU_SRA   = 6'b001101,
      ALU_BEQ   = 6'b010000,
      ALU_BNE   = 6'b010001,
      ALU_BLT   = 6'b010100,
      ALU_BGE   = 6'b010101,
      ALU_BLTU  = 6'b010110,
      ALU_BGEU  = 6'b010111,
      ALU_LUI   = 6'b110000,
      ALU_AUIPC = 6'b110001,
      ALU_NOP   = 6'b111111
   } alu_op_t;

   typedef enum logic [4:0] {
      MEM_NOP = 5'b00000,
      MEM_LB  = 5'b10000,
      MEM_LH  = 5'b10001,
      MEM_LW  = 5'b10010,
      MEM_LBU = 5'b10100,
      MEM_LHU = 5'b10101,
      MEM_SB  = 5'b11000,
      MEM_SH  = 5'b11001,
      MEM_SW  = 5'b11010
   } mem_op_t;

   typedef struct packed {
      logic [11:0] imm;
      reg_t        rs1;
      logic [2:0]  funct3;
      reg_t        rd;
      logic [6:0]  opcode;
   } itype_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_t       rs2;
      reg_t       rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } stype_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      reg_t       rs2;
      reg_t       rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } btype_t;

   typedef struct packed {
      logic [19:0] imm;
      reg_t        rd;
      logic [6:0]  opcode;
   } utype_t;

   typedef struct packed {
      logic [6:0] funct7;
      reg_t       rs2;
      reg_t       rs1;
      logic [2:0] funct3;
      reg_t       rd;
      logic [6:0] opcode;
   } rtype_t;

   typedef union packed {
      itype_t itype;
      stype_t stype;
      btype_t btype;
      utype_t utype;
      rtype_t rtype;
   } instruction_t;

   typedef struct packed {
      logic [XLEN-1:0] instr;
      logic [XLEN-1:0] pc;
      format_t         format;
      alu_op_t         alu_op;
      mem_op_t         mem_op;
      reg_t            rs1;
      reg_t            rs2;
      reg_t            rd;
      logic [XLEN-1:0] rs1_data;
      logic [XLEN-1:0] rs2_data;
      logic [XLEN-1:0] imm;
      logic            is_branch;
      logic            illegal;
   } pipeline_bus_t;

endpackage

`default_nettype wire

/* hdl/decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder import core_pkg::*; (
   input  wire             clk,
   input  wire             rst_n_i,
   input  logic [XLEN-1:0] instruction_i,
   input  logic [XLEN-1:0] pc_i,
   rf_port_if.user         rf,
   output pipeline_bus_t   id_bus_o
);

   instruction_t    instr;
   opcode_t         opcode;
   format_t         fmt;
   alu_op_t         alu_op;
   mem_op_t         mem_op;
   reg_t            rs1;
   reg_t            rs2;
   reg_t            rd;
   logic            is_branch;
   logic            illegal;
   logic [XLEN-1:0] imm;

   assign instr  = instruction_t'(instruction_i);
   assign opcode = opcode_t'(instr.rtype.opcode);

   imm_generator im_gen (
      .instr_i  (instruction_i),
      .format_i (fmt),
      .imm_o    (imm)
   );

   always_comb begin
      fmt       = NOP;
      alu_op    = ALU_NOP;
      mem_op    = MEM_NOP;
      rs1       = '0;
      rs2       = '0;
      rd        = '0;
      is_branch = 1'b0;
      illegal   = 1'b0;
      case (opcode)
         I_OP: begin
            fmt = I_FORMAT;
            rs1 = instr.itype.rs1;
            rd  = instr.itype.rd;
            // The canonical NOP is ADDI x0, x0, 0.
            if (instr.itype.rs1 == '0 && instr.itype.rd == '0 && instr.itype.imm == '0) begin
               alu_op = ALU_NOP;
            end else begin
               alu_op = alu_op_t'({ARITHM_PRFX,
                                   instr.itype.imm[10] && (instr.itype.funct3 == 3'b101),
                                   instr.itype.funct3});
            end
         end
         RR_OP: begin
            fmt    = R_FORMAT;
            rs1    = instr.rtype.rs1;
            rs2    = instr.rtype.rs2;
            rd     = instr.rtype.rd;
            alu_op = alu_op_t'({ARITHM_PRFX,
                                instr.rtype.funct7[5] && (instr.rtype.funct3 == 3'b000 ||
                                                          instr.rtype.funct3 == 3'b101),
                                instr.rtype.funct3});
         end
         LUI_OP: begin
            fmt    = U_FORMAT;
            rd     = instr.utype.rd;
            alu_op = ALU_LUI;
         end
         AUI_OP: begin
            fmt    = U_FORMAT;
            rd     = instr.utype.rd;
            alu_op = ALU_AUIPC;
         end
         B_OP: begin
            fmt       = B_FORMAT;
            rs1       = instr.btype.rs1;
            rs2       = instr.btype.rs2;
            is_branch = 1'b1;
            alu_op    = alu_op_t'({BRANCH_PRFX, 1'b0, instr.btype.funct3});
            // funct3 values 010 and 011 are not branch conditions.
            illegal   = (instr.btype.funct3[2:1] == 2'b01);
         end
         L_OP: begin
            fmt    = I_FORMAT;
            rs1    = instr.itype.rs1;
            rd     = instr.itype.rd;
            mem_op = mem_op_t'({LOAD_PRFX, instr.itype.funct3});
         end
         S_OP: begin
            fmt    = S_FORMAT;
            rs1    = instr.stype.rs1;
            rs2    = instr.stype.rs2;
            mem_op = mem_op_t'({STORE_PRFX, instr.stype.funct3});
         end
         default: begin
            illegal = 1'b1;
         end
      endcase
   end

   assign rf.raddr_a = rs1;
   assign rf.raddr_b = rs2;

   always_comb begin
      id_bus_o.instr     = instruction_i;
      id_bus_o.pc        = pc_i;
      id_bus_o.format    = fmt;
      id_bus_o.alu_op    = alu_op;
      id_bus_o.mem_op    = mem_op;
      id_bus_o.rs1       = rs1;
      id_bus_o.rs2       = rs2;
      id_bus_o.rd        = rd;
      id_bus_o.rs1_data  = rf.rdata_a;
      id_bus_o.rs2_data  = rf.rdata_b;
      id_bus_o.imm       = imm;
      id_bus_o.is_branch = is_branch;
      id_bus_o.illegal   = illegal;
   end

   // Once reset is released the instruction register always holds a fetched word.
   a_instr_known: assert property (@(posedge clk) disable iff (!rst_n_i)
      !$isunknown(instruction_i))
      else $error("Decoder received an unknown instruction word.");

endmodule

`default_nettype wire

/* hdl/imm_generator.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_generator import core_pkg::*; (
   input  logic [XLEN-1:0] instr_i,
   input  format_t         format_i,
   output logic [XLEN-1:0] imm_o
);

   instruction_t instr;

   assign instr = instruction_t'(instr_i);

   always_comb begin
      case (format_i)
         I_FORMAT: imm_o = {{20{instr.itype.imm[11]}}, instr.itype.imm};
         S_FORMAT: imm_o = {{20{instr.stype.imm_hi[6]}}, instr.stype.imm_hi, instr.stype.imm_lo};
         // Branch offsets are in half words, so bit zero is always clear.
         B_FORMAT: imm_o = {{19{instr.btype.imm_12}}, instr.btype.imm_12, instr.btype.imm_11,
                            instr.btype.imm_10_5, instr.btype.imm_4_1, 1'b0};
         U_FORMAT: imm_o = {instr.utype.imm, 12'b0};
         default:  imm_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/pc_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_counter import core_pkg::*; (
   input  wire             clk,
   input  wire             rst_n_i,
   input  logic            step_i,
   input  logic            take_i,
   input  logic [XLEN-1:0] imm_i,
   output logic [XLEN-1:0] pc_o
);

   logic [XLEN-1:0] pc_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pc_q <= RESET_PC;
      end else if (step_i) begin
         if (take_i) begin
            pc_q <= pc_q + imm_i;
         end else begin
            pc_q <= pc_q + XLEN'(4);
         end
      end
   end

   assign pc_o = pc_q;

   // A branch offset from the decoder could break alignment.
   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i) pc_o[1:0] == 2'b00)
      else $error("Program counter is not word aligned.");

endmodule

`default_nettype wire

/* hdl/regfile_2r1w.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile_2r1w import core_pkg::*; (
   input wire      clk,
   rf_port_if.file rf
);

   // Register x0 has no storage and always reads as zero.
   logic [XLEN-1:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (rf.wen && (rf.waddr != '0)) begin
         regs[rf.waddr] <= rf.wdata;
      end
   end

   always_comb begin
      rf.rdata_a = '0;
      rf.rdata_b = '0;
      if (rf.raddr_a != '0) begin
         rf.rdata_a = regs[rf.raddr_a];
      end
      if (rf.raddr_b != '0) begin
         rf.rdata_b = regs[rf.raddr_b];
      end
   end

   // The write strobe and the address come from different blocks.
   a_waddr_known: assert property (@(posedge clk) rf.wen |-> !$isunknown(rf.waddr))
      else $error("Register write with unknown address.");

endmodule

`default_nettype wire

/* hdl/rf_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface rf_port_if import core_pkg::*; ();

   reg_t            raddr_a;
   reg_t            raddr_b;
   logic [XLEN-1:0] rdata_a;
   logic [XLEN-1:0] rdata_b;
   logic            wen;
   reg_t            waddr;
   logic [XLEN-1:0] wdata;

   modport file (
      input  raddr_a, raddr_b, wen, waddr, wdata,
      output rdata_a, rdata_b
   );

   // Users only see the read side; the write side is driven at the top level.
   modport user (
      output raddr_a, raddr_b,
      input  rdata_a, rdata_b
   );

endinterface

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_top import core_pkg::*; (
   input  wire             clk,
   input  wire             rst_n_i,
   input  logic [XLEN-1:0] imem_data_i,
   output logic [XLEN-1:0] imem_addr_o,
   output logic            retire_o,
   output logic [XLEN-1:0] retire_pc_o,
   output logic            wb_en_o,
   output reg_t            wb_addr_o,
   output logic [XLEN-1:0] wb_data_o,
   output logic            halted_o
);

   pipeline_bus_t   id_bus;
   logic [XLEN-1:0] instr;
   logic [XLEN-1:0] pc;
   logic [XLEN-1:0] alu_result;
   logic            step;
   logic            rf_wen;
   logic            take;

   rf_port_if rf_port ();

   core_control ctrl_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .imem_data_i (imem_data_i),
      .id_bus_i    (id_bus),
      .instr_o     (instr),
      .step_o      (step),
      .rf_wen_o    (rf_wen),
      .retire_o    (retire_o),
      .halted_o    (halted_o)
   );

   pc_counter pc_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .step_i  (step),
      .take_i  (take),
      .imm_i   (id_bus.imm),
      .pc_o    (pc)
   );

   decoder dec_i (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .instruction_i (instr),
      .pc_i          (pc),
      .rf            (rf_port),
      .id_bus_o      (id_bus)
   );

   regfile_2r1w rf_i (
      .clk (clk),
      .rf  (rf_port)
   );

   alu alu_i (
      .id_bus_i (id_bus),
      .result_o (alu_result),
      .taken_o  (take)
   );

   // The write port closes the loop from the ALU back into the file.
   assign rf_port.wen   = rf_wen;
   assign rf_port.waddr = id_bus.rd;
   assign rf_port.wdata = alu_result;

   assign imem_addr_o = pc;
   assign retire_pc_o = pc;
   assign wb_en_o     = rf_wen;
   assign wb_addr_o   = id_bus.rd;
   assign wb_data_o   = alu_result;

endmodule

`default_nettype wire

/* project.f */
hdl/core_pkg.sv
hdl/rf_port_if.sv
hdl/imm_generator.sv
hdl/regfile_2r1w.sv
hdl/decoder.sv
hdl/alu.sv
hdl/pc_counter.sv
hdl/core_control.sv
hdl/rv_core_top.sv
test/tb_rv_core.sv

/* test/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core import core_pkg::*; ();

   localparam logic [6:0] OPC_IMM    = 7'b0010011;
   localparam logic [6:0] OPC_REG    = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   localparam int RESET_CYCLES = 5;
   localparam int HALT_WATCH   = 3;
   // Sum of the program lengths below, and the number of programs run.
   localparam int PROG_WORDS   = 129;
   localparam int RUNS         = 8;
   localparam int CYCLE_LIMIT  = 2 * PROG_WORDS + RUNS * (RESET_CYCLES + HALT_WATCH + 4) + 64;

   logic            clk;
   logic            rst_n;
   logic [XLEN-1:0] imem_data;
   wire  [XLEN-1:0] imem_addr;
   wire             retire;
   wire  [XLEN-1:0] retire_pc;
   wire             wb_en;
   reg_t            wb_addr;
   wire  [XLEN-1:0] wb_data;
   wire             halted;

   logic [31:0] imem [0:127];
   logic [31:0] prog [$];
   logic [31:0] exp_pc [$];
   bit          exp_wen [$];
   reg_t        exp_rd [$];
   logic [31:0] exp_data [$];
   logic [31:0] got_pc [$];
   bit          got_wen [$];
   reg_t        got_rd [$];
   logic [31:0] got_data [$];

   logic [31:0] rng_state = 32'd52490;
   int          word_errors = 0;
   int          reg_errors = 0;
   int          flag_errors = 0;
   int          cycle_count = 0;

   rv_core_top rv_core_top_i (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .imem_data_i (imem_data),
      .imem_addr_o (imem_addr),
      .retire_o    (retire),
      .retire_pc_o (retire_pc),
      .wb_en_o     (wb_en),
      .wb_addr_o   (wb_addr),
      .wb_data_o   (wb_data),
      .halted_o    (halted)
   );

   // Instruction memory answers in the same cycle.
   assign imem_data = imem[imem_addr[8:2]];

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the core did not finish the programs within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [31:0] enc_i(input logic [2:0] f3, input reg_t rd, input reg_t rs1,
                                         input logic [11:0] imm, input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_t rd, input reg_t rs1, input reg_t rs2);
      return {f7, rs2, rs1, f3, rd, OPC_REG};
   endfunction

   function automatic logic [31:0] enc_u(input logic [6:0] opc, input reg_t rd,
                                         input logic [19:0] imm);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] enc_b(input logic [2:0] f3, input reg_t rs1, input reg_t rs2,
                                         input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] enc_s(input logic [2:0] f3, input reg_t rs1, input reg_t rs2,
                                         input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] enc_j(input reg_t rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   // RV32I integer results by funct3, with alt selecting SUB and SRA.
   function automatic logic [31:0] ref_alu(input logic [2:0] f3, input bit alt,
                                           input logic [31:0] a, input logic [31:0] b);
      logic signed [31:0] sa;
      sa = $signed(a);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return (sa < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: return (a < b) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5: begin
            if (alt) return sa >>> b[4:0];
            return a >> b[4:0];
         end
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic bit branch_holds(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
      case (f3)
         3'b000: return a == b;
         3'b001: return a != b;
         3'b100: return $signed(a) < $signed(b);
         3'b101: return $signed(a) >= $signed(b);
         3'b110: return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
      if (got !== exp) begin
         word_errors++;
         $display("mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic check_reg(input reg_t got, input reg_t exp, input string what);
      if (got !== exp) begin
         reg_errors++;
         $display("mismatch at %0t: %s got x%0d expected x%0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input bit got, input bit exp, input string what);
      if (got !== exp) begin
         flag_errors++;
         $display("mismatch at %0t: %s got %0b expected %0b", $time, what, got, exp);
      end
   endtask

   function automatic logic [31:0] next_pc();
      return 32'(prog.size() * 4);
   endfunction

   task automatic begin_program();
      prog.delete();
      exp_pc.delete();
      exp_wen.delete();
      exp_rd.delete();
      exp_data.delete();
   endtask

   task automatic expect_retire(input logic [31:0] pc, input bit wen, input reg_t rd,
                                input logic [31:0] data);
      exp_pc.push_back(pc);
      exp_wen.push_back(wen);
      exp_rd.push_back(rd);
      exp_data.push_back(data);
   endtask

   // Straight-line instruction, retired at the address it is placed at.
   task automatic op(input logic [31:0] word, input bit wen, input reg_t rd,
                     input logic [31:0] data);
      expect_retire(next_pc(), wen, rd, data);
      prog.push_back(word);
   endtask

   task automatic push_li(input reg_t rd, input logic [31:0] v);
      logic [31:0] adj;
      logic [19:0] hi;
      adj = v + 32'h800;
      hi = adj[31:12];
      op(enc_u(OPC_LUI, rd, hi), 1'b1, rd, {hi, 12'h000});
      op(enc_i(3'b000, rd, rd, v[11:0], OPC_IMM), 1'b1, rd, v);
   endtask

   task automatic finish_program();
      op(enc_i(3'b000, 5'd0, 5'd0, 12'h000, OPC_SYSTEM), 1'b0, 5'd0, 32'd0);
   endtask

   task automatic load_program();
      for (int i = 0; i < 128; i++) begin
         imem[i] = enc_i(3'b000, 5'd0, 5'd0, 12'(i), OPC_IMM);
      end
      foreach (prog[i]) imem[i] = prog[i];
   endtask

   task automatic reset_core();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic run_program();
      int n;
      int halt_n;
      int last_ret_n;
      int halted_cycles;
      n = 0;
      halt_n = -1;
      last_ret_n = -1;
      halted_cycles = 0;
      got_pc.delete();
      got_wen.delete();
      got_rd.delete();
      got_data.delete();
      while (halted_cycles < HALT_WATCH) begin
         @(negedge clk);
         if (n == 0) check_flag(halted, 1'b0, "halted right after reset");
         if (halted) begin
            if (halt_n < 0) halt_n = n;
            halted_cycles++;
            check_flag(retire, 1'b0, "retire while halted");
         end else begin
            check_flag(retire, n[0], "retire every second cycle");
         end
         if (retire) begin
            got_pc.push_back(retire_pc);
            got_wen.push_back(wb_en);
            got_rd.push_back(wb_addr);
            got_data.push_back(wb_data);
            last_ret_n = n;
         end else begin
            check_flag(wb_en, 1'b0, "write-back without retire");
         end
         n++;
      end
      check_word(32'(halt_n), 32'(last_ret_n + 1), "halt cycle after the trap");
   endtask

   task automatic compare_events(input string name);
      check_word(32'(got_pc.size()), 32'(exp_pc.size()), {name, " retire count"});
      for (int i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
         check_word(got_pc[i], exp_pc[i], $sformatf("%s retire %0d pc", name, i));
         check_flag(got_wen[i], exp_wen[i], $sformatf("%s retire %0d wb_en", name, i));
         if (exp_wen[i]) begin
            check_reg(got_rd[i], exp_rd[i], $sformatf("%s retire %0d wb_addr", name, i));
            check_word(got_data[i], exp_data[i], $sformatf("%s retire %0d wb_data", name, i));
         end
      end
   endtask

   task automatic run_test(input string name);
      load_program();
      reset_core();
      run_program();
      compare_events(name);
   endtask

   task automatic test_imm_arith();
      logic [2:0]  f3_list [0:8] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
      logic [31:0] a;
      logic [31:0] r;
      logic [11:0] imm;
      reg_t        rd;
      begin_program();
      for (int i = 0; i < 9; i++) begin
         a = next_rand();
         r = next_rand();
         if (f3_list[i] == 3'd1 || f3_list[i] == 3'd5) begin
            imm = {(i == 8) ? 7'b0100000 : 7'b0000000, r[4:0]};
         end else begin
            imm = r[11:0];
         end
         rd = 5'(i + 2);
         push_li(5'd1, a);
         op(enc_i(f3_list[i], rd, 5'd1, imm, OPC_IMM), 1'b1, rd,
            ref_alu(f3_list[i], i == 8, a, sext12(imm)));
      end
      finish_program();
      run_test("immediate arithmetic");
   endtask

   task automatic test_reg_arith();
      logic [2:0]  f3_list [0:9] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
      bit          alt_list [0:9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
      logic [31:0] a;
      logic [31:0] b;
      reg_t        rd;
      begin_program();
      for (int i = 0; i < 10; i++) begin
         a = next_rand();
         b = next_rand();
         rd = 5'(i + 3);
         push_li(5'd1, a);
         push_li(5'd2, b);
         op(enc_r(alt_list[i] ? 7'b0100000 : 7'b0000000, f3_list[i], rd, 5'd1, 5'd2), 1'b1, rd,
            ref_alu(f3_list[i], alt_list[i], a, b));
      end
      finish_program();
      run_test("register arithmetic");
   endtask

   task automatic test_upper_imm();
      logic [31:0] r;
      logic [31:0] pc;
      logic [19:0] u;
      begin_program();
      for (int i = 0; i < 3; i++) begin
         r = next_rand();
         u = r[31:12];
         op(enc_u(OPC_LUI, 5'(3 + i), u), 1'b1, 5'(3 + i), {u, 12'h000});
         r = next_rand();
         u = r[19:0];
         pc = next_pc();
         op(enc_u(OPC_AUIPC, 5'(8 + i), u), 1'b1, 5'(8 + i), pc + {u, 12'h000});
      end
      finish_program();
      run_test("lui and auipc");
   endtask

   task automatic pick_operands(input logic [2:0] f3, input bit want, input logic [31:0] x,
                                input logic [31:0] y, output reg_t ra, output reg_t rb);
      if (branch_holds(f3, x, x) == want) begin
         ra = 5'd1;
         rb = 5'd1;
      end else if (branch_holds(f3, x, y) == want) begin
         ra = 5'd1;
         rb = 5'd2;
      end else begin
         ra = 5'd2;
         rb = 5'd1;
      end
   endtask

   task automatic test_branches();
      logic [2:0]  conds [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      logic [31:0] x;
      logic [31:0] y;
      logic [31:0] pc;
      logic [11:0] mark;
      reg_t        ra;
      reg_t        rb;
      begin_program();
      x = next_rand();
      y = next_rand();
      if (x == y) y = x ^ 32'h1;
      push_li(5'd1, x);
      push_li(5'd2, y);
      // A taken branch skips the marker write placed right behind it.
      for (int c = 0; c < 6; c++) begin
         for (int want = 1; want >= 0; want--) begin
            pick_operands(conds[c], want[0], x, y, ra, rb);
            pc = next_pc();
            mark = 12'(2 * c + want + 1);
            expect_retire(pc, 1'b0, 5'd0, 32'd0);
            prog.push_back(enc_b(conds[c], ra, rb, 13'd8));
            if (want == 0) expect_retire(pc + 32'd4, 1'b1, 5'd7, sext12(mark));
            prog.push_back(enc_i(3'b000, 5'd7, 5'd0, mark, OPC_IMM));
         end
      end
      finish_program();
      run_test("branches");
   endtask

   task automatic test_x0_and_timing();
      logic [31:0] v;
      begin_program();
      v = next_rand();
      push_li(5'd5, v);
      op(enc_i(3'b000, 5'd0, 5'd5, 12'd77, OPC_IMM), 1'b1, 5'd0, v + 32'd77);
      op(enc_u(OPC_LUI, 5'd0, 20'habcde), 1'b1, 5'd0, 32'habcde000);
      op(enc_r(7'b0000000, 3'b000, 5'd6, 5'd0, 5'd0), 1'b1, 5'd6, 32'd0);
      op(enc_r(7'b0000000, 3'b110, 5'd7, 5'd0, 5'd5), 1'b1, 5'd7, v);
      op(enc_i(3'b000, 5'd0, 5'd0, 12'h000, OPC_IMM), 1'b1, 5'd0, 32'd0);
      finish_program();
      run_test("x0 and timing");
   endtask

   task automatic run_trap_program(input string name, input logic [31:0] word);
      begin_program();
      op(enc_i(3'b000, 5'd1, 5'd0, 12'd5, OPC_IMM), 1'b1, 5'd1, 32'd5);
      op(word, 1'b0, 5'd0, 32'd0);
      run_test(name);
   endtask

   task automatic test_traps();
      run_trap_program("store trap", enc_s(3'b010, 5'd2, 5'd1, 12'h010));
      run_trap_program("load trap", enc_i(3'b010, 5'd3, 5'd0, 12'h004, OPC_LOAD));
      run_trap_program("jal trap", enc_j(5'd1, 21'h000008));
   endtask

   initial begin
      rst_n = 1'b0;
      test_imm_arith();
      test_reg_arith();
      test_upper_imm();
      test_branches();
      test_x0_and_timing();
      test_traps();
      $display("Mismatches: %0d word, %0d register, %0d flag after %0d cycles",
               word_errors, reg_errors, flag_errors, cycle_count);
      if (word_errors + reg_errors + flag_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
